//--- logic/playfield_pkg.sv
`default_nettype none

package playfield_pkg;

    typedef logic [15:0] word_t;                // one vram data word
    typedef logic [15:0] addr_t;                // vram word address
    typedef logic [7:0]  color_t;               // colour index
    typedef logic [10:0] hres_t;                // horizontal count
    typedef logic [1:0]  bpp_t;                 // depth code

    localparam bpp_t BPP_1_ATTR = 2'd0;         // 1 bpp, fore/back nibbles in same word
    localparam bpp_t BPP_4      = 2'd1;         // 4 bpp, two words per group
    localparam bpp_t BPP_8      = 2'd2;         // 8 bpp, four words per group
    localparam bpp_t BPP_XX     = 2'd3;         // treated as 8 bpp

    // eight indices, element 0 is the leftmost pixel and the top byte
    typedef logic [0:7][7:0] pixels_t;

    // one fetched display word, seen raw or as a 1 bpp attribute word
    typedef union packed {
        word_t raw;                             // 4/8 bpp data and storage
        struct packed {
            logic [3:0] back;                   // colour for clear bits
            logic [3:0] fore;                   // colour for set bits
            logic [7:0] bits;                   // pixel 0 at bit 7
        } attr;
    } disp_word_u;

endpackage

`default_nettype wire

//--- logic/fetch_words_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_words_if import playfield_pkg::*; ();

    logic       words_ready;                    // pulse, previous group stable
    disp_word_u disp_word0;                     // first word (attr word in 1 bpp)
    disp_word_u disp_word1;
    disp_word_u disp_word2;
    disp_word_u disp_word3;                     // last word (8 bpp only)
    logic       buf_full;                       // pending buffer holds unshown pixels

    modport fetch (
        output words_ready, disp_word0, disp_word1, disp_word2, disp_word3,
        input  buf_full
    );

    modport expand (
        input  words_ready, disp_word0, disp_word1, disp_word2, disp_word3,
        output buf_full
    );

endinterface

`default_nettype wire

//--- logic/bitmap_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module bitmap_fetch import playfield_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       mem_fetch_i,        // fetch allowed this line
    input  wire logic       mem_fetch_start_i,  // rewind to line start
    input  wire bpp_t       bpp_i,              // picks 1, 2 or 4 words per group
    input  wire addr_t      line_start_addr_i,
    input  wire word_t      vram_data_i,        // valid cycle after vram_sel_o
    output      logic       vram_sel_o,         // registered read strobe
    output      addr_t      vram_addr_o,        // registered read address
    fetch_words_if.fetch    words
);

    typedef enum logic [2:0] {
        FETCH_IDLE,                             // line not fetching
        FETCH_ADDR,                             // first read of group, waits on buf_full
        FETCH_WAIT,                             // first read in flight
        FETCH_READ_0,                           // word0 on bus
        FETCH_READ_1,                           // word1 on bus
        FETCH_READ_2,                           // word2 on bus
        FETCH_READ_3                            // word3 on bus
    } fetch_st_t;

    fetch_st_t state;
    fetch_st_t state_next;
    addr_t     fetch_addr;                      // next word to request
    logic      issue;                           // request a vram word this cycle
    logic      ready_next;                      // words_ready for previous group
    logic      initial_buf;                     // first group of line, nothing to hand over

    always_comb begin
        state_next = state;
        issue      = 1'b0;
        ready_next = 1'b0;
        case (state)
            FETCH_IDLE: begin
                if (mem_fetch_i) begin
                    state_next = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                if (!mem_fetch_i) begin
                    state_next = FETCH_IDLE;    // line fetch window over
                end else if (!words.buf_full) begin
                    issue      = 1'b1;          // word0 request
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                issue      = (bpp_i != BPP_1_ATTR);  // word1 request
                ready_next = !initial_buf;      // old words still intact next cycle
                state_next = FETCH_READ_0;
            end
            FETCH_READ_0: begin
                if (bpp_i == BPP_1_ATTR) begin
                    state_next = FETCH_ADDR;    // single word group done
                end else begin
                    issue      = (bpp_i != BPP_4);  // word2 request for 8 bpp
                    state_next = FETCH_READ_1;
                end
            end
            FETCH_READ_1: begin
                if (bpp_i == BPP_4) begin
                    state_next = FETCH_ADDR;
                end else begin
                    issue      = 1'b1;          // word3 request
                    state_next = FETCH_READ_2;
                end
            end
            FETCH_READ_2: begin
                state_next = FETCH_READ_3;
            end
            FETCH_READ_3: begin
                state_next = FETCH_ADDR;
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state             <= FETCH_IDLE;
            vram_sel_o        <= 1'b0;
            vram_addr_o       <= '0;
            fetch_addr        <= '0;
            initial_buf       <= 1'b0;
            words.words_ready <= 1'b0;
        end else begin
            state             <= state_next;
            vram_sel_o        <= issue;
            words.words_ready <= ready_next;
            if (issue) begin
                vram_addr_o <= fetch_addr;      // address goes out with strobe
                fetch_addr  <= fetch_addr + 1'b1;
            end
            if (state == FETCH_WAIT) begin
                initial_buf <= 1'b0;            // later groups hand over
            end
            if (mem_fetch_start_i) begin
                fetch_addr  <= line_start_addr_i;  // new line
                initial_buf <= 1'b1;
            end
        end
    end

    // capture returning words, one per read state
    always_ff @(posedge clk) begin
        case (state)
            FETCH_READ_0: words.disp_word0.raw <= vram_data_i;
            FETCH_READ_1: words.disp_word1.raw <= vram_data_i;
            FETCH_READ_2: words.disp_word2.raw <= vram_data_i;
            FETCH_READ_3: words.disp_word3.raw <= vram_data_i;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pixel_expand.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_expand import playfield_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire bpp_t       bpp_i,
    input  wire logic       mem_fetch_start_i,  // drop any leftover pixels
    input  wire logic       buf_take_i,         // shifter took pending pixels
    output      pixels_t    pend_pixels_o,      // pixels waiting for shifter
    fetch_words_if.expand   words
);

    // each bit picks fore or back, upper nibble zero
    function automatic pixels_t expand_1bpp(disp_word_u w);
        pixels_t p;
        for (int i = 0; i < 8; i++) begin
            p[i] = {4'h0, w.attr.bits[7 - i] ? w.attr.fore : w.attr.back};
        end
        return p;
    endfunction

    // nibbles left to right, word0 first
    function automatic pixels_t expand_4bpp(disp_word_u w0, disp_word_u w1);
        logic [31:0] nib;
        pixels_t     p;
        nib = {w0.raw, w1.raw};
        for (int i = 0; i < 8; i++) begin
            p[i] = {4'h0, nib[31 - 4 * i -: 4]};
        end
        return p;
    endfunction

    always_ff @(posedge clk) begin
        if (words.words_ready) begin
            case (bpp_i)
                BPP_1_ATTR: pend_pixels_o <= expand_1bpp(words.disp_word0);
                BPP_4:      pend_pixels_o <= expand_4bpp(words.disp_word0, words.disp_word1);
                BPP_8,
                BPP_XX:     pend_pixels_o <= {words.disp_word0.raw, words.disp_word1.raw,
                                              words.disp_word2.raw, words.disp_word3.raw};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            words.buf_full <= 1'b0;
        end else begin
            if (buf_take_i) begin
                words.buf_full <= 1'b0;
            end
            if (words.words_ready) begin
                words.buf_full <= 1'b1;         // new load wins over take of old one
            end
            if (mem_fetch_start_i) begin
                words.buf_full <= 1'b0;         // line restart
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pixel_scanout.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_scanout import playfield_pkg::*; #(
    parameter int H_SCANOUT_BEGIN = 30          // h count offset of visible area
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,
    input  wire logic       mem_fetch_i,        // scanout only starts inside fetch window
    input  wire logic       mem_fetch_start_i,  // latch window counts
    input  wire logic       end_of_line_i,      // forces scanout off
    input  wire hres_t      vid_left_i,
    input  wire hres_t      vid_right_i,
    input  wire logic [1:0] h_repeat_i,         // extra cycles per pixel
    input  wire color_t     border_color_i,
    input  wire color_t     colorbase_i,
    input  wire pixels_t    pend_pixels_i,
    output      logic       buf_take_o,         // pending pixels copied this cycle
    output      color_t     pf_color_index_o
);

    hres_t      start_hcount;                   // count that loads first group
    hres_t      end_hcount;                     // last count showing data
    logic       scanout;                        // shifter running
    logic       scanout_start;
    logic       scanout_stop;
    logic       next_pixel;                     // repeat count expired
    logic [1:0] h_cnt;                          // repeat countdown
    logic [2:0] col;                            // pixel within group
    pixels_t    pixels;                         // shifter, element 0 on output

    assign scanout_start = (h_count_i == start_hcount) && mem_fetch_i;
    assign scanout_stop  = (h_count_i == end_hcount) || end_of_line_i;
    assign next_pixel    = scanout && !scanout_stop && (h_cnt == 2'd0);
    assign buf_take_o    = scanout_start || (next_pixel && (col == 3'd7));

    assign pf_color_index_o = pixels[0] ^ colorbase_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_hcount <= '0;
            end_hcount   <= '0;
            scanout      <= 1'b0;
            h_cnt        <= '0;
            col          <= '0;
        end else begin
            if (mem_fetch_start_i) begin
                start_hcount <= hres_t'(H_SCANOUT_BEGIN) + vid_left_i;
                end_hcount   <= hres_t'(H_SCANOUT_BEGIN) + vid_right_i;
            end
            if (scanout_start) begin
                scanout <= 1'b1;
                h_cnt   <= h_repeat_i;          // first pixel held full time
                col     <= '0;
            end else if (scanout) begin
                if (h_cnt != 2'd0) begin
                    h_cnt <= h_cnt - 1'b1;
                end else begin
                    h_cnt <= h_repeat_i;
                    col   <= col + 1'b1;        // wraps to next group
                end
            end
            if (scanout_stop) begin
                scanout <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scanout_start) begin
            pixels <= pend_pixels_i;            // first group of line
        end else if (next_pixel) begin
            if (col == 3'd7) begin
                pixels <= pend_pixels_i;        // group done, reload
            end else begin
                pixels <= {pixels[1:7], border_color_i};  // border fills behind
            end
        end else if (!scanout || scanout_stop) begin
            pixels[0] <= border_color_i;        // outside window
        end
    end

endmodule

`default_nettype wire

//--- logic/line_scan.sv
`timescale 1ns/1ns
`default_nettype none

module line_scan import playfield_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       end_of_line_i,
    input  wire logic       end_of_frame_i,     // wins over end of line
    input  wire addr_t      start_addr_i,       // frame start, sampled at frame end
    input  wire word_t      line_len_i,         // words between line starts
    input  wire logic [1:0] v_repeat_i,         // extra repeats of each line
    output      addr_t      line_start_addr_o
);

    logic [1:0] v_cnt;                          // repeats left for this line

    always_ff @(posedge clk) begin
        if (reset_i) begin
            v_cnt             <= '0;
            line_start_addr_o <= '0;
        end else if (end_of_frame_i) begin
            v_cnt             <= v_repeat_i;    // next frame from top
            line_start_addr_o <= start_addr_i;
        end else if (end_of_line_i) begin
            if (v_cnt != 2'd0) begin
                v_cnt <= v_cnt - 1'b1;          // show same line again
            end else begin
                v_cnt             <= v_repeat_i;
                line_start_addr_o <= line_start_addr_o + line_len_i;  // step one line
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/playfield_top.sv
`timescale 1ns/1ns
`default_nettype none

module playfield_top import playfield_pkg::*; #(
    parameter int H_SCANOUT_BEGIN = 30          // h count where visible area begins
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,          // horizontal timing count
    input  wire logic       mem_fetch_i,        // fetch enable level
    input  wire logic       mem_fetch_start_i,  // once per line, before fetch
    input  wire logic       end_of_line_i,      // last count of line
    input  wire logic       end_of_frame_i,     // last line of frame
    input  wire color_t     border_color_i,
    input  wire hres_t      vid_left_i,         // left window edge
    input  wire hres_t      vid_right_i,        // right window edge
    input  wire word_t      vram_data_i,
    input  wire addr_t      start_addr_i,       // frame start word address
    input  wire word_t      line_len_i,         // words per line
    input  wire color_t     colorbase_i,        // xor'd onto every index
    input  wire bpp_t       bpp_i,
    input  wire logic [1:0] h_repeat_i,
    input  wire logic [1:0] v_repeat_i,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    output      color_t     pf_color_index_o
);

    logic    buf_take;                          // scanout copied pending buffer
    pixels_t pend_pixels;                       // next eight pixels
    addr_t   line_start_addr;                   // first word of current line

    fetch_words_if i_fetch_words ();

    bitmap_fetch i_bitmap_fetch (
        .clk               (clk),
        .reset_i           (reset_i),
        .mem_fetch_i       (mem_fetch_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .bpp_i             (bpp_i),
        .line_start_addr_i (line_start_addr),
        .vram_data_i       (vram_data_i),
        .vram_sel_o        (vram_sel_o),
        .vram_addr_o       (vram_addr_o),
        .words             (i_fetch_words.fetch)
    );

    pixel_expand i_pixel_expand (
        .clk               (clk),
        .reset_i           (reset_i),
        .bpp_i             (bpp_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .buf_take_i        (buf_take),
        .pend_pixels_o     (pend_pixels),
        .words             (i_fetch_words.expand)
    );

    pixel_scanout #(
        .H_SCANOUT_BEGIN   (H_SCANOUT_BEGIN)
    ) i_pixel_scanout (
        .clk               (clk),
        .reset_i           (reset_i),
        .h_count_i         (h_count_i),
        .mem_fetch_i       (mem_fetch_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .end_of_line_i     (end_of_line_i),
        .vid_left_i        (vid_left_i),
        .vid_right_i       (vid_right_i),
        .h_repeat_i        (h_repeat_i),
        .border_color_i    (border_color_i),
        .colorbase_i       (colorbase_i),
        .pend_pixels_i     (pend_pixels),
        .buf_take_o        (buf_take),
        .pf_color_index_o  (pf_color_index_o)
    );

    line_scan i_line_scan (
        .clk               (clk),
        .reset_i           (reset_i),
        .end_of_line_i     (end_of_line_i),
        .end_of_frame_i    (end_of_frame_i),
        .start_addr_i      (start_addr_i),
        .line_len_i        (line_len_i),
        .v_repeat_i        (v_repeat_i),
        .line_start_addr_o (line_start_addr)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 10                // full clock period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;    // half period per phase
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_playfield.sv
`timescale 1ns/1ns
`default_nettype none

module tb_playfield import playfield_pkg::*; ();

    localparam int H_SCANOUT_BEGIN = 30;        // same offset as dut
    localparam int LINE_COUNTS     = 200;       // h counts per line
    localparam int FETCH_LAST      = 180;       // last count with mem_fetch_i high
    localparam int RESET_CYCLES    = 16;
    localparam int CLK_PERIOD      = 10;

    typedef struct packed {
        bpp_t       bpp;
        logic [1:0] h_repeat;
        logic [1:0] v_repeat;
        addr_t      start_addr;
        word_t      line_len;
        color_t     colorbase;
        color_t     border;
        hres_t      vid_left;
        hres_t      vid_right;                  // keep H_SCANOUT_BEGIN + right <= FETCH_LAST
        logic [3:0] lines;                      // lines in this frame
    } case_t;

    localparam int NUM_CASES = 7;
    localparam case_t CASES [NUM_CASES] = '{
        '{BPP_1_ATTR, 2'd0, 2'd0, 16'h0100, 16'd20,  8'h00, 8'h5a, 11'd0,  11'd150, 4'd3},
        '{BPP_4,      2'd1, 2'd1, 16'h2000, 16'd40,  8'h3c, 8'h81, 11'd5,  11'd140, 4'd4},
        '{BPP_8,      2'd2, 2'd2, 16'hfff0, 16'd64,  8'ha5, 8'h12, 11'd10, 11'd147, 4'd4},
        '{BPP_XX,     2'd3, 2'd0, 16'h4321, 16'd100, 8'h0f, 8'hee, 11'd2,  11'd130, 4'd2},
        '{BPP_1_ATTR, 2'd3, 2'd3, 16'h0100, 16'd7,   8'hff, 8'h00, 11'd20, 11'd100, 4'd5},
        '{BPP_8,      2'd0, 2'd1, 16'h8000, 16'd300, 8'h44, 8'h99, 11'd1,  11'd149, 4'd3},
        '{BPP_4,      2'd0, 2'd0, 16'h7777, 16'd33,  8'h00, 8'h66, 11'd0,  11'd120, 4'd2}
    };

    logic       clk;
    logic       reset_i;
    hres_t      h_count_i;
    logic       mem_fetch_i;
    logic       mem_fetch_start_i;
    logic       end_of_line_i;
    logic       end_of_frame_i;
    color_t     border_color_i;
    hres_t      vid_left_i;
    hres_t      vid_right_i;
    word_t      vram_data_i;
    addr_t      start_addr_i;
    word_t      line_len_i;
    color_t     colorbase_i;
    bpp_t       bpp_i;
    logic [1:0] h_repeat_i;
    logic [1:0] v_repeat_i;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    color_t     pf_color_index_o;

    word_t      vram [0:65535];                 // whole 16-bit word space
    logic       rd_sel;                         // read seen in the cycle just ending
    addr_t      rd_addr;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_tb_clock (.clk_o(clk));

    playfield_top #(
        .H_SCANOUT_BEGIN   (H_SCANOUT_BEGIN)
    ) i_playfield_top (
        .clk               (clk),
        .reset_i           (reset_i),
        .h_count_i         (h_count_i),
        .mem_fetch_i       (mem_fetch_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .end_of_line_i     (end_of_line_i),
        .end_of_frame_i    (end_of_frame_i),
        .border_color_i    (border_color_i),
        .vid_left_i        (vid_left_i),
        .vid_right_i       (vid_right_i),
        .vram_data_i       (vram_data_i),
        .start_addr_i      (start_addr_i),
        .line_len_i        (line_len_i),
        .colorbase_i       (colorbase_i),
        .bpp_i             (bpp_i),
        .h_repeat_i        (h_repeat_i),
        .v_repeat_i        (v_repeat_i),
        .vram_sel_o        (vram_sel_o),
        .vram_addr_o       (vram_addr_o),
        .pf_color_index_o  (pf_color_index_o)
    );

    // taps of x^32 + x^22 + x^2 + x + 1 with the new bit entering at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_vram();
        logic [31:0] lfsr;
        word_t       w;
        lfsr = 32'h12ba;
        for (int a = 0; a < 65536; a++) begin
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);         // one step per bit
                w    = {w[14:0], lfsr[0]};
            end
            vram[a] = w;
        end
    endtask

    // vram read model samples the strobe mid cycle and answers one cycle later
    always @(negedge clk) begin
        rd_sel  = vram_sel_o;
        rd_addr = vram_addr_o;
    end

    always @(posedge clk) begin
        #1;
        if (rd_sel) begin
            vram_data_i = vram[rd_addr];
        end
    end

    function automatic word_t word_at(input addr_t base, input int offs);
        addr_t a;
        a = base + addr_t'(offs);               // wraps like the fetch counter
        return vram[a];
    endfunction

    // source pixel k of a line before colourbase
    function automatic color_t ref_pixel(input bpp_t bpp, input addr_t base, input int k);
        int          g;
        int          p;
        word_t       w;
        logic [31:0] nib;
        logic [63:0] bytes;
        g = k / 8;
        p = k % 8;
        case (bpp)
            BPP_1_ATTR: begin
                w = word_at(base, g);
                return w[7 - p] ? {4'h0, w[11:8]} : {4'h0, w[15:12]};  // fore : back
            end
            BPP_4: begin
                nib = {word_at(base, 2 * g), word_at(base, 2 * g + 1)};
                return {4'h0, nib[31 - 4 * p -: 4]};
            end
            default: begin                      // 8 bpp and code 3
                bytes = {word_at(base, 4 * g), word_at(base, 4 * g + 1),
                         word_at(base, 4 * g + 2), word_at(base, 4 * g + 3)};
                return bytes[63 - 8 * p -: 8];
            end
        endcase
    endfunction

    task automatic check_value(input logic [15:0] got, input logic [15:0] want,
                               input string what);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // drives one full line of h counts and checks outputs mid cycle
    task automatic run_line(input case_t tc, input addr_t base, input int row, input int ln);
        int     s;
        int     e;
        int     k;
        int     reads;
        color_t want;
        s     = H_SCANOUT_BEGIN + int'(tc.vid_left);    // shifter loads here
        e     = H_SCANOUT_BEGIN + int'(tc.vid_right);   // last data count
        reads = 0;
        for (int c = 0; c < LINE_COUNTS; c++) begin
            @(posedge clk);
            #1;
            h_count_i         = hres_t'(c);
            mem_fetch_start_i = (c == 0);
            mem_fetch_i       = (c >= 1) && (c <= FETCH_LAST);
            end_of_line_i     = (c == LINE_COUNTS - 1);
            end_of_frame_i    = 1'b0;
            @(negedge clk);
            // idle at count 1 and address state at count 2 put the first strobe at 3
            if (c <= 3) begin
                check_value(vram_sel_o, (c == 3),
                            $sformatf("row %0d line %0d count %0d strobe", row, ln, c));
            end
            if (vram_sel_o) begin
                check_value(vram_addr_o, base + addr_t'(reads),    // words in order
                            $sformatf("row %0d line %0d read %0d address", row, ln, reads));
                reads++;
            end
            if (c > s && c <= e) begin
                k    = (c - s - 1) / (int'(tc.h_repeat) + 1);
                want = ref_pixel(tc.bpp, base, k);
            end else begin
                want = tc.border;               // outside window
            end
            check_value(pf_color_index_o, want ^ tc.colorbase,
                        $sformatf("row %0d line %0d count %0d", row, ln, c));
        end
    endtask

    // watchdog sized from the table
    initial begin : watchdog
        int cycles;
        cycles = RESET_CYCLES + 200;            // reset plus margin
        for (int r = 0; r < NUM_CASES; r++) begin
            cycles += 1 + int'(CASES[r].lines) * LINE_COUNTS;
        end
        #(cycles * CLK_PERIOD);
        $display("timeout: the playfield run did not finish in the expected time");
        $display("test failed");
        $fatal(1);
    end

    initial begin : stimulus
        addr_t base;
        int    step;
        reset_i           = 1'b1;
        h_count_i         = '0;
        mem_fetch_i       = 1'b0;
        mem_fetch_start_i = 1'b0;
        end_of_line_i     = 1'b0;
        end_of_frame_i    = 1'b0;
        border_color_i    = '0;
        vid_left_i        = '0;
        vid_right_i       = '0;
        vram_data_i       = '0;
        start_addr_i      = '0;
        line_len_i        = '0;
        colorbase_i       = '0;
        bpp_i             = BPP_1_ATTR;
        h_repeat_i        = '0;
        v_repeat_i        = '0;
        rd_sel            = 1'b0;
        rd_addr           = '0;
        fill_vram();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        for (int r = 0; r < NUM_CASES; r++) begin
            @(posedge clk);
            #1;
            bpp_i          = CASES[r].bpp;      // gap cycle restarts the frame
            h_repeat_i     = CASES[r].h_repeat;
            v_repeat_i     = CASES[r].v_repeat;
            start_addr_i   = CASES[r].start_addr;
            line_len_i     = CASES[r].line_len;
            colorbase_i    = CASES[r].colorbase;
            border_color_i = CASES[r].border;
            vid_left_i     = CASES[r].vid_left;
            vid_right_i    = CASES[r].vid_right;
            h_count_i      = '0;
            mem_fetch_i    = 1'b0;
            end_of_line_i  = 1'b0;
            end_of_frame_i = 1'b1;
            for (int ln = 0; ln < int'(CASES[r].lines); ln++) begin
                step = ln / (int'(CASES[r].v_repeat) + 1);  // repeated lines share data
                base = CASES[r].start_addr + addr_t'(step * int'(CASES[r].line_len));
                run_line(CASES[r], base, r, ln);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/playfield_pkg.sv
logic/fetch_words_if.sv
logic/bitmap_fetch.sv
logic/pixel_expand.sv
logic/pixel_scanout.sv
logic/line_scan.sv
logic/playfield_top.sv
tb/tb_clock.sv
tb/tb_playfield.sv

//--- Makefile
# verilator build and run of the playfield testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_playfield -Mdir obj_dir -o sim_playfield

run: compile
	@out="$$(./obj_dir/sim_playfield)"; echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir
